// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= frv_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== src/frv_core.sv ====
// Control core top level
// Three-stage command pipeline with interrupt and counter blocks
`default_nettype none

module frv_core import frv_pkg::*; #(
  parameter logic [31:0] FRV_PC_RESET_VALUE = 32'h8000_0000,  // First trace PC
  parameter logic [31:0] MMIO_BASE_ADDR     = 32'h0000_1000,  // Timer registers
  parameter logic [31:0] MMIO_BASE_MASK     = 32'hFFFF_F000
) (
  input  logic        g_clk,             // Global clock
  input  logic        reset,             // Sync reset
  input  logic        cmd_valid,
  input  logic [31:0] cmd_word,
  input  logic        int_nmi,           // Non-maskable interrupt
  input  logic        int_external,
  input  logic [3:0]  int_extern_cause,
  input  logic        int_software,
  output logic        trs_valid,
  output logic [31:0] trs_pc,
  output logic [31:0] trs_instr,
  output logic        trs_trap,
  output frv_cause_t  trs_cause,
  output logic        rd_valid,
  output logic [31:0] rd_wdata,
  output logic        int_mtime          // Timer interrupt pending
);

  // ----------------------------------------
  // Pipeline wires
  logic             d_valid, d_illegal;
  frv_op_t          d_op;
  frv_csr_t         d_sel;
  logic [IMM_W-1:0] d_imm;
  logic [31:0]      d_word;
  logic             x_valid, x_trap, x_rd_valid;
  logic [31:0]      x_word, x_rd_data;
  frv_cause_t       x_cause;

  // Control and side-band wires
  logic             mstatus_mie, mie_meie, mie_mtie, mie_msie;
  logic             mip_meip, mip_mtip, mip_msip;
  logic             inhibit_cy, inhibit_tm, inhibit_ir;
  logic             int_trap_req, int_trap_ack;
  frv_cause_t       int_trap_cause;
  logic             instr_ret, ti_pending;
  logic [31:0]      ctr_cycle, ctr_instret;
  logic             mmio_en, mmio_wen, mmio_error;
  logic [31:0]      mmio_addr, mmio_wdata, mmio_rdata;

  assign int_mtime = mip_mtip;

  frv_decode i_decode (
    .g_clk, .reset, .cmd_valid, .cmd_word,
    .d_valid, .d_op, .d_sel, .d_imm, .d_illegal, .d_word
  );

  frv_execute #(
    .MMIO_BASE_ADDR (MMIO_BASE_ADDR),
    .MMIO_BASE_MASK (MMIO_BASE_MASK)
  ) i_execute (
    .g_clk, .reset,
    .d_valid, .d_op, .d_sel, .d_imm, .d_illegal, .d_word,
    .int_trap_req, .int_trap_cause, .mip_meip, .mip_mtip, .mip_msip,
    .ctr_cycle, .ctr_instret, .mmio_rdata, .mmio_error,
    .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie,
    .inhibit_cy, .inhibit_tm, .inhibit_ir, .int_trap_ack,
    .mmio_en, .mmio_wen, .mmio_addr, .mmio_wdata,
    .x_valid, .x_word, .x_trap, .x_cause, .x_rd_valid, .x_rd_data
  );

  frv_writeback #(
    .FRV_PC_RESET_VALUE (FRV_PC_RESET_VALUE)
  ) i_writeback (
    .g_clk, .reset,
    .x_valid, .x_word, .x_trap, .x_cause, .x_rd_valid, .x_rd_data,
    .trs_valid, .trs_pc, .trs_instr, .trs_trap, .trs_cause,
    .rd_valid, .rd_wdata, .instr_ret
  );

  frv_interrupt i_interrupts (
    .g_clk, .reset, .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie,
    .nmi_pending (int_nmi),
    .ex_pending  (int_external),
    .ex_cause    (int_extern_cause),
    .ti_pending  (ti_pending),
    .sw_pending  (int_software),
    .int_trap_ack, .mip_meip, .mip_mtip, .mip_msip,
    .int_trap_req, .int_trap_cause
  );

  frv_counters #(
    .MMIO_BASE_ADDR (MMIO_BASE_ADDR),
    .MMIO_BASE_MASK (MMIO_BASE_MASK)
  ) i_counters (
    .g_clk, .reset, .instr_ret, .inhibit_cy, .inhibit_tm, .inhibit_ir,
    .mmio_en, .mmio_wen, .mmio_addr, .mmio_wdata,
    .timer_interrupt (ti_pending),
    .ctr_cycle, .ctr_instret, .mmio_rdata, .mmio_error
  );

endmodule

`default_nettype wire

// ==== src/frv_counters.sv ====
// Counter block
// Cycle, instret and mtime counters with an MMIO port over mtime and
// mtimecmp, and the machine timer compare
`default_nettype none

module frv_counters import frv_pkg::*; #(
  parameter logic [31:0] MMIO_BASE_ADDR = 32'h0000_1000,
  parameter logic [31:0] MMIO_BASE_MASK = 32'hFFFF_F000
) (
  input  logic        g_clk,
  input  logic        reset,
  input  logic        instr_ret,
  input  logic        inhibit_cy,
  input  logic        inhibit_tm,
  input  logic        inhibit_ir,
  input  logic        mmio_en,
  input  logic        mmio_wen,
  input  logic [31:0] mmio_addr,
  input  logic [31:0] mmio_wdata,
  output logic        timer_interrupt,  // mtime reached mtimecmp
  output logic [31:0] ctr_cycle,        // Low words for CSR reads
  output logic [31:0] ctr_instret,
  output logic [31:0] mmio_rdata,
  output logic        mmio_error
);

  logic [63:0] cycle_q;
  logic [63:0] instret_q;
  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic [31:0] offset;
  logic        reg_hit;
  logic        mmio_write;

  // ----------------------------------------
  // Address decode
  assign offset  = mmio_addr & ~MMIO_BASE_MASK;
  assign reg_hit = ((mmio_addr & MMIO_BASE_MASK) == (MMIO_BASE_ADDR & MMIO_BASE_MASK)) &&
                   (offset[31:4] == 28'd0) &&
                   (offset[3:0] inside {MMIO_MTIME_LO, MMIO_MTIME_HI,
                                        MMIO_MTIMECMP_LO, MMIO_MTIMECMP_HI});

  assign mmio_error = mmio_en && !reg_hit;
  assign mmio_write = mmio_en && mmio_wen && reg_hit;

  always_comb begin
    case (offset[3:0])
      MMIO_MTIME_LO:    mmio_rdata = mtime_q[31:0];
      MMIO_MTIME_HI:    mmio_rdata = mtime_q[63:32];
      MMIO_MTIMECMP_LO: mmio_rdata = mtimecmp_q[31:0];
      MMIO_MTIMECMP_HI: mmio_rdata = mtimecmp_q[63:32];
      default:          mmio_rdata = '0;
    endcase
  end

  // ----------------------------------------
  // Counters
  always_ff @(posedge g_clk) begin
    if (reset) begin
      cycle_q    <= '0;
      instret_q  <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;                 // No timer interrupt out of reset
    end else begin
      if (!inhibit_cy) cycle_q <= cycle_q + 64'd1;
      if (instr_ret && !inhibit_ir) instret_q <= instret_q + 64'd1;
      if (mmio_write && (offset[3:0] == MMIO_MTIME_LO)) begin
        mtime_q[31:0] <= mmio_wdata;    // Write wins over the tick
      end else if (mmio_write && (offset[3:0] == MMIO_MTIME_HI)) begin
        mtime_q[63:32] <= mmio_wdata;
      end else if (!inhibit_tm) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (mmio_write && (offset[3:0] == MMIO_MTIMECMP_LO)) mtimecmp_q[31:0]  <= mmio_wdata;
      if (mmio_write && (offset[3:0] == MMIO_MTIMECMP_HI)) mtimecmp_q[63:32] <= mmio_wdata;
    end
  end

  assign timer_interrupt = mtime_q >= mtimecmp_q;
  assign ctr_cycle       = cycle_q[31:0];
  assign ctr_instret     = instret_q[31:0];

endmodule

`default_nettype wire

// ==== src/frv_decode.sv ====
// Decode stage
// Splits each command word into fields and flags illegal commands
`default_nettype none

module frv_decode import frv_pkg::*; (
  input  logic             g_clk,      // Global clock
  input  logic             reset,      // Sync reset
  input  logic             cmd_valid,  // Command strobe
  input  logic [31:0]      cmd_word,   // Raw command
  output logic             d_valid,    // Command held in decode
  output frv_op_t          d_op,       // Opcode
  output frv_csr_t         d_sel,      // CSR select or MMIO word index
  output logic [IMM_W-1:0] d_imm,      // Immediate
  output logic             d_illegal,  // Unknown or disallowed command
  output logic [31:0]      d_word      // Word kept for the trace
);

  frv_op_t  op;
  frv_csr_t sel;
  logic     csr_op;                    // Command addresses a CSR
  logic     known_sel;
  logic     read_only;
  logic     illegal;

  assign op  = frv_op_t'(cmd_word[31:28]);
  assign sel = frv_csr_t'(cmd_word[27:24]);

  assign csr_op    = (op == OP_CSRW) || (op == OP_CSRR);
  assign known_sel = sel inside {CSR_MSTATUS, CSR_MIE, CSR_MIP,
                                 CSR_CYCLE, CSR_INSTRET, CSR_INHIBIT};
  assign read_only = sel inside {CSR_MIP, CSR_CYCLE, CSR_INSTRET};

  // MMIO offsets are checked by the counter block
  assign illegal = !(op inside {OP_NOP, OP_CSRW, OP_CSRR, OP_MMIOW, OP_MMIOR}) ||
                   (csr_op && !known_sel) ||
                   ((op == OP_CSRW) && read_only);

  always_ff @(posedge g_clk) begin
    if (reset) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= cmd_valid;
    end
  end

  always_ff @(posedge g_clk) begin
    if (cmd_valid) begin
      d_op      <= op;
      d_sel     <= sel;
      d_imm     <= cmd_word[IMM_W-1:0];
      d_illegal <= illegal;
      d_word    <= cmd_word;
    end
  end

endmodule

`default_nettype wire

// ==== src/frv_execute.sv ====
// Execute stage
// Owns mstatus, mie and the counter inhibits, performs CSR and MMIO
// accesses and decides traps for the command in flight
`default_nettype none

module frv_execute import frv_pkg::*; #(
  parameter logic [31:0] MMIO_BASE_ADDR = 32'h0000_1000,
  parameter logic [31:0] MMIO_BASE_MASK = 32'hFFFF_F000
) (
  input  logic             g_clk,
  input  logic             reset,
  input  logic             d_valid,
  input  frv_op_t          d_op,
  input  frv_csr_t         d_sel,
  input  logic [IMM_W-1:0] d_imm,
  input  logic             d_illegal,
  input  logic [31:0]      d_word,
  input  logic             int_trap_req,    // Interrupt waiting
  input  frv_cause_t       int_trap_cause,
  input  logic             mip_meip,
  input  logic             mip_mtip,
  input  logic             mip_msip,
  input  logic [31:0]      ctr_cycle,       // Low words of the counters
  input  logic [31:0]      ctr_instret,
  input  logic [31:0]      mmio_rdata,
  input  logic             mmio_error,
  output logic             mstatus_mie,     // Global interrupt enable
  output logic             mie_meie,
  output logic             mie_mtie,
  output logic             mie_msie,
  output logic             inhibit_cy,
  output logic             inhibit_tm,
  output logic             inhibit_ir,
  output logic             int_trap_ack,    // Interrupt taken this cycle
  output logic             mmio_en,
  output logic             mmio_wen,
  output logic [31:0]      mmio_addr,
  output logic [31:0]      mmio_wdata,
  output logic             x_valid,
  output logic [31:0]      x_word,
  output logic             x_trap,
  output frv_cause_t       x_cause,
  output logic             x_rd_valid,
  output logic [31:0]      x_rd_data
);

  logic        is_mmio;
  logic        trap;
  logic        csr_write;
  logic        rd_op;
  frv_cause_t  cause;
  logic [31:0] csr_rdata;

  // ----------------------------------------
  // Trap decision
  assign is_mmio      = (d_op == OP_MMIOW) || (d_op == OP_MMIOR);
  assign int_trap_ack = d_valid && !d_illegal && int_trap_req;
  assign mmio_en      = d_valid && is_mmio && !d_illegal && !int_trap_req;
  assign trap         = d_valid && (d_illegal || int_trap_req || (mmio_en && mmio_error));

  always_comb begin
    if (d_illegal) begin
      cause = CAUSE_ILLEGAL;             // Illegal beats interrupt
    end else if (int_trap_req) begin
      cause = int_trap_cause;
    end else begin
      cause = CAUSE_MMIO_ERR;
    end
  end

  // MMIO master, select is the word index
  assign mmio_wen   = mmio_en && (d_op == OP_MMIOW);
  assign mmio_addr  = (MMIO_BASE_ADDR & MMIO_BASE_MASK) | {26'd0, d_sel, 2'b00};
  assign mmio_wdata = {{(32-IMM_W){1'b0}}, d_imm};

  // ----------------------------------------
  // CSR access
  assign csr_write = d_valid && !trap && (d_op == OP_CSRW);
  assign rd_op     = (d_op == OP_CSRR) || (d_op == OP_MMIOR);

  always_comb begin
    csr_rdata = '0;
    case (d_sel)
      CSR_MSTATUS: csr_rdata[MSTATUS_MIE_BIT] = mstatus_mie;
      CSR_MIE: begin
        csr_rdata[MIE_MEIE_BIT] = mie_meie;
        csr_rdata[MIE_MTIE_BIT] = mie_mtie;
        csr_rdata[MIE_MSIE_BIT] = mie_msie;
      end
      CSR_MIP: begin
        csr_rdata[MIE_MEIE_BIT] = mip_meip;
        csr_rdata[MIE_MTIE_BIT] = mip_mtip;
        csr_rdata[MIE_MSIE_BIT] = mip_msip;
      end
      CSR_CYCLE:   csr_rdata = ctr_cycle;
      CSR_INSTRET: csr_rdata = ctr_instret;
      CSR_INHIBIT: begin
        csr_rdata[INHIBIT_CY_BIT] = inhibit_cy;
        csr_rdata[INHIBIT_TM_BIT] = inhibit_tm;
        csr_rdata[INHIBIT_IR_BIT] = inhibit_ir;
      end
      default: csr_rdata = '0;
    endcase
  end

  // Only a taken interrupt masks further interrupts
  always_ff @(posedge g_clk) begin
    if (reset) begin
      mstatus_mie <= 1'b0;
      mie_meie    <= 1'b0;
      mie_mtie    <= 1'b0;
      mie_msie    <= 1'b0;
      inhibit_cy  <= 1'b0;
      inhibit_tm  <= 1'b0;
      inhibit_ir  <= 1'b0;
    end else if (int_trap_ack) begin
      mstatus_mie <= 1'b0;
    end else if (csr_write) begin
      case (d_sel)
        CSR_MSTATUS: mstatus_mie <= d_imm[MSTATUS_MIE_BIT];
        CSR_MIE: begin
          mie_meie <= d_imm[MIE_MEIE_BIT];
          mie_mtie <= d_imm[MIE_MTIE_BIT];
          mie_msie <= d_imm[MIE_MSIE_BIT];
        end
        CSR_INHIBIT: begin
          inhibit_cy <= d_imm[INHIBIT_CY_BIT];
          inhibit_tm <= d_imm[INHIBIT_TM_BIT];
          inhibit_ir <= d_imm[INHIBIT_IR_BIT];
        end
        default: ;                       // Read-only selects never get here
      endcase
    end
  end

  // ----------------------------------------
  // Result register towards writeback
  always_ff @(posedge g_clk) begin
    if (reset) begin
      x_valid    <= 1'b0;
      x_trap     <= 1'b0;
      x_rd_valid <= 1'b0;
    end else begin
      x_valid    <= d_valid;
      x_trap     <= trap;
      x_rd_valid <= d_valid && !trap && rd_op;
    end
  end

  always_ff @(posedge g_clk) begin
    if (d_valid) begin
      x_word    <= d_word;
      x_cause   <= cause;
      x_rd_data <= (d_op == OP_MMIOR) ? mmio_rdata : csr_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/frv_interrupt.sv ====
// Interrupt block
// Registers pending lines, applies enables, picks the highest cause
`default_nettype none

module frv_interrupt import frv_pkg::*; (
  input  logic       g_clk,
  input  logic       reset,
  input  logic       mstatus_mie,
  input  logic       mie_meie,
  input  logic       mie_mtie,
  input  logic       mie_msie,
  input  logic       nmi_pending,     // Input levels
  input  logic       ex_pending,
  input  logic [3:0] ex_cause,
  input  logic       ti_pending,
  input  logic       sw_pending,
  input  logic       int_trap_ack,    // Execute took the request
  output logic       mip_meip,
  output logic       mip_mtip,
  output logic       mip_msip,
  output logic       int_trap_req,
  output frv_cause_t int_trap_cause
);

  logic       nmi_q;                  // NMI latch
  logic [3:0] ex_cause_q;
  logic       ex_take;
  logic       sw_take;
  logic       ti_take;

  // NMI ranks first, so an ack while latched is always the NMI
  always_ff @(posedge g_clk) begin
    if (reset) begin
      nmi_q    <= 1'b0;
      mip_meip <= 1'b0;
      mip_mtip <= 1'b0;
      mip_msip <= 1'b0;
    end else begin
      nmi_q    <= nmi_pending || (nmi_q && !int_trap_ack);
      mip_meip <= ex_pending;
      mip_mtip <= ti_pending;
      mip_msip <= sw_pending;
    end
  end

  always_ff @(posedge g_clk) begin
    ex_cause_q <= ex_cause;           // Follows the pending bit
  end

  assign ex_take = mstatus_mie && mie_meie && mip_meip;
  assign sw_take = mstatus_mie && mie_msie && mip_msip;
  assign ti_take = mstatus_mie && mie_mtie && mip_mtip;

  assign int_trap_req = nmi_q || ex_take || sw_take || ti_take;

  always_comb begin
    if (nmi_q) begin
      int_trap_cause = CAUSE_NMI;
    end else if (ex_take) begin
      int_trap_cause = CAUSE_EXT_BASE + {2'b00, ex_cause_q};
    end else if (sw_take) begin
      int_trap_cause = CAUSE_MSI;
    end else if (ti_take) begin
      int_trap_cause = CAUSE_MTI;
    end else begin
      int_trap_cause = CAUSE_MEI;     // Unused without a request
    end
  end

endmodule

`default_nettype wire

// ==== src/frv_pkg.sv ====
// Control core shared definitions
// Command word fields, opcodes, CSR selects, MMIO offsets and trap causes
`default_nettype none

package frv_pkg;

  // Command word layout ----------------
  localparam int IMM_W = 16;                // Immediate in bits 15..0

  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,                        // No effect
    OP_CSRW  = 4'd1,                        // Write CSR from immediate
    OP_CSRR  = 4'd2,                        // Read CSR to result
    OP_MMIOW = 4'd3,                        // Write timer register
    OP_MMIOR = 4'd4                         // Read timer register
  } frv_op_t;

  typedef enum logic [3:0] {
    CSR_MSTATUS = 4'd0,
    CSR_MIE     = 4'd1,
    CSR_MIP     = 4'd2,                     // Read only
    CSR_CYCLE   = 4'd3,                     // Low word, read only
    CSR_INSTRET = 4'd4,                     // Low word, read only
    CSR_INHIBIT = 4'd5
  } frv_csr_t;

  // Implemented CSR bits ---------------
  localparam int MSTATUS_MIE_BIT = 3;
  localparam int MIE_MSIE_BIT    = 3;       // Same positions in mip
  localparam int MIE_MTIE_BIT    = 7;
  localparam int MIE_MEIE_BIT    = 11;
  localparam int INHIBIT_CY_BIT  = 0;
  localparam int INHIBIT_TM_BIT  = 1;
  localparam int INHIBIT_IR_BIT  = 2;

  // Byte offsets from the MMIO base
  localparam logic [3:0] MMIO_MTIME_LO    = 4'd0;
  localparam logic [3:0] MMIO_MTIME_HI    = 4'd4;
  localparam logic [3:0] MMIO_MTIMECMP_LO = 4'd8;
  localparam logic [3:0] MMIO_MTIMECMP_HI = 4'd12;

  // Trap causes ------------------------
  typedef logic [5:0] frv_cause_t;

  localparam frv_cause_t CAUSE_ILLEGAL  = 6'd2;
  localparam frv_cause_t CAUSE_MSI      = 6'd3;
  localparam frv_cause_t CAUSE_MMIO_ERR = 6'd5;
  localparam frv_cause_t CAUSE_MTI      = 6'd7;
  localparam frv_cause_t CAUSE_MEI      = 6'd11;
  localparam frv_cause_t CAUSE_EXT_BASE = 6'd16;  // Plus the 4-bit external code
  localparam frv_cause_t CAUSE_NMI      = 6'd63;

endpackage

`default_nettype wire

// ==== src/frv_writeback.sv ====
// Writeback stage
// Retires each command onto the trace port and keeps the trace PC
`default_nettype none

module frv_writeback import frv_pkg::*; #(
  parameter logic [31:0] FRV_PC_RESET_VALUE = 32'h8000_0000
) (
  input  logic        g_clk,
  input  logic        reset,
  input  logic        x_valid,
  input  logic [31:0] x_word,
  input  logic        x_trap,
  input  frv_cause_t  x_cause,
  input  logic        x_rd_valid,
  input  logic [31:0] x_rd_data,
  output logic        trs_valid,   // Retire strobe
  output logic [31:0] trs_pc,      // PC of the retired command
  output logic [31:0] trs_instr,
  output logic        trs_trap,
  output frv_cause_t  trs_cause,
  output logic        rd_valid,    // Result present
  output logic [31:0] rd_wdata,
  output logic        instr_ret    // Non-trapped retire, to counters
);

  logic [31:0] next_pc;            // PC handed to the next retire

  always_ff @(posedge g_clk) begin
    if (reset) begin
      trs_valid <= 1'b0;
      trs_trap  <= 1'b0;
      rd_valid  <= 1'b0;
      instr_ret <= 1'b0;
      next_pc   <= FRV_PC_RESET_VALUE;
    end else begin
      trs_valid <= x_valid;
      trs_trap  <= x_valid && x_trap;
      rd_valid  <= x_valid && x_rd_valid;
      instr_ret <= x_valid && !x_trap;
      if (x_valid) begin
        next_pc <= next_pc + 32'd4;  // Trapped retires advance too
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (x_valid) begin
      trs_pc    <= next_pc;
      trs_instr <= x_word;
      trs_cause <= x_cause;
      rd_wdata  <= x_rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/frv_pkg.sv
src/frv_decode.sv
src/frv_execute.sv
src/frv_writeback.sv
src/frv_interrupt.sv
src/frv_counters.sv
src/frv_core.sv
verif/frv_core_tb.sv

// ==== verif/frv_core_tb.sv ====
// Control core testbench
// Random and directed commands against an in-order reference model,
// checked at every retire on the trace port
`default_nettype none

module frv_core_tb import frv_pkg::*; ();

  logic        g_clk;
  logic        reset;
  logic        cmd_valid;
  logic [31:0] cmd_word;
  logic        int_nmi;
  logic        int_external;
  logic [3:0]  int_extern_cause;
  logic        int_software;
  logic        trs_valid;
  logic [31:0] trs_pc;
  logic [31:0] trs_instr;
  logic        trs_trap;
  frv_cause_t  trs_cause;
  logic        rd_valid;
  logic [31:0] rd_wdata;
  logic        int_mtime;

  // Reference model state ------------------
  logic [31:0] exp_q[$];                 // Issued words, oldest first
  int unsigned issue_q[$];               // Clock edge count at issue
  int unsigned clk_edges;                // Rising edges since start
  logic [31:0] m_pc;
  logic [31:0] m_instret;
  logic        m_mie, m_meie, m_mtie, m_msie;
  logic        m_icy, m_itm, m_iir;      // Inhibits
  logic [63:0] m_mtimecmp;
  logic        m_mtip;                   // Expected timer pending
  logic        nmi_armed;                // NMI latch
  logic [31:0] last_cycle;               // Last cycle read result
  logic [31:0] seed;
  int          sent;

  frv_core dut_i (
    .g_clk, .reset, .cmd_valid, .cmd_word,
    .int_nmi, .int_external, .int_extern_cause, .int_software,
    .trs_valid, .trs_pc, .trs_instr, .trs_trap, .trs_cause,
    .rd_valid, .rd_wdata, .int_mtime
  );

  initial begin
    g_clk = 1'b0;
    forever #5 g_clk = ~g_clk;
  end

  always @(posedge g_clk) begin
    clk_edges++;
  end

  // Helpers ----------------------------------
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [31:0] cmd(input logic [3:0] op, input logic [3:0] sel,
                                      input logic [15:0] imm);
    return {op, sel, 8'h00, imm};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge g_clk);
      cmd_valid = 1'b0;
    end
  endtask

  task automatic send(input logic [31:0] word);
    @(negedge g_clk);
    cmd_valid = 1'b1;
    cmd_word  = word;
    exp_q.push_back(word);
    issue_q.push_back(clk_edges);
    sent++;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= 10) begin
        fail_run("pipeline did not drain within 10 cycles");
      end else begin
        idle(1);
        waited++;
      end
    end
    idle(1);                             // Counters settle
  endtask

  task automatic wait_mtime(input logic level);
    int waited;
    waited = 0;
    while (int_mtime !== level) begin
      if (waited >= 30) begin
        fail_run("int_mtime did not reach the expected level in time");
      end else begin
        idle(1);
        waited++;
      end
    end
  endtask

  // ----------------------------------------
  // Retire check and model update
  task automatic check_retire();
    logic [31:0] word;
    int unsigned issued;
    logic [3:0]  op, sel;
    logic [15:0] imm;
    logic        illegal, is_csr, mmio_bad, int_take, trap, rd_exp, rd_known;
    logic [5:0]  int_cause, cause;
    logic [31:0] rd_val;
    word    = exp_q.pop_front();
    issued  = issue_q.pop_front();
    op      = word[31:28];
    sel     = word[27:24];
    imm     = word[15:0];
    is_csr  = (op == 4'd1) || (op == 4'd2);
    illegal = (op > 4'd4) || (is_csr && sel > 4'd5) ||
              ((op == 4'd1) && (sel inside {4'd2, 4'd3, 4'd4}));
    mmio_bad = ((op == 4'd3) || (op == 4'd4)) && (sel > 4'd3);
    int_take = 1'b1;                      // NMI, external, software, timer
    if (nmi_armed) int_cause = CAUSE_NMI;
    else if (m_mie && m_meie && int_external)
      int_cause = CAUSE_EXT_BASE + {2'b00, int_extern_cause};
    else if (m_mie && m_msie && int_software) int_cause = CAUSE_MSI;
    else if (m_mie && m_mtie && m_mtip) int_cause = CAUSE_MTI;
    else begin
      int_take  = 1'b0;
      int_cause = 6'd0;
    end
    trap  = illegal || int_take || mmio_bad;
    cause = illegal ? CAUSE_ILLEGAL : (int_take ? int_cause : CAUSE_MMIO_ERR);
    rd_exp   = !trap && ((op == 4'd2) || (op == 4'd4));
    rd_known = 1'b1;
    rd_val   = '0;
    if (op == 4'd2) begin
      case (sel)
        4'd0: rd_val[3] = m_mie;
        4'd1: rd_val = {20'd0, m_meie, 3'd0, m_mtie, 3'd0, m_msie, 3'd0};
        4'd2: rd_val = {20'd0, int_external, 3'd0, m_mtip, 3'd0, int_software, 3'd0};
        4'd4: rd_val = m_instret;
        4'd5: rd_val = {29'd0, m_iir, m_itm, m_icy};
        default: rd_known = 1'b0;         // Cycle count
      endcase
    end else if (op == 4'd4) begin
      if (sel == 4'd2) rd_val = m_mtimecmp[31:0];
      else if (sel == 4'd3) rd_val = m_mtimecmp[63:32];
      else rd_known = 1'b0;               // Free-running mtime
    end
    assert (clk_edges == issued + 3)
      else value_error("trs_valid latency", clk_edges - issued, 32'd3);
    assert (trs_pc == m_pc) else value_error("trs_pc", trs_pc, m_pc);
    assert (trs_instr == word) else value_error("trs_instr", trs_instr, word);
    assert (trs_trap == trap) else value_error("trs_trap", {31'd0, trs_trap}, {31'd0, trap});
    if (trap) begin
      assert (trs_cause == cause)
        else value_error("trs_cause", {26'd0, trs_cause}, {26'd0, cause});
    end
    assert (rd_valid == rd_exp) else value_error("rd_valid", {31'd0, rd_valid}, {31'd0, rd_exp});
    if (rd_exp && rd_known) begin
      assert (rd_wdata == rd_val) else value_error("rd_wdata", rd_wdata, rd_val);
    end
    if (rd_exp && !rd_known && op == 4'd2) last_cycle = rd_wdata;
    m_pc = m_pc + 32'd4;
    if (trap && !illegal && int_take) begin
      m_mie = 1'b0;                       // Taken interrupt masks
      if (int_cause == CAUSE_NMI) nmi_armed = int_nmi;
    end
    if (!trap && op == 4'd1) begin
      case (sel)
        4'd0: m_mie = imm[3];
        4'd1: {m_meie, m_mtie, m_msie} = {imm[11], imm[7], imm[3]};
        4'd5: {m_iir, m_itm, m_icy} = imm[2:0];
        default: ;
      endcase
    end
    if (!trap && op == 4'd3 && sel == 4'd2) m_mtimecmp[31:0] = {16'd0, imm};
    if (!trap && op == 4'd3 && sel == 4'd3) m_mtimecmp[63:32] = {16'd0, imm};
    if (!trap && !m_iir) m_instret = m_instret + 32'd1;
  endtask

  always @(negedge g_clk) begin
    if (!reset && trs_valid) begin
      if (exp_q.size() == 0) fail_run("retire seen with no command outstanding");
      else check_retire();
    end
  end

  // ----------------------------------------
  // Directed sequences
  task automatic cycle_reads();
    logic [31:0] c1;
    send(cmd(OP_CSRR, CSR_CYCLE, 16'h0));
    drain();
    c1 = last_cycle;
    assert (c1 != 32'd0)
      else fail_run($sformatf("FAIL rd_wdata %h, expected a non-zero cycle count", c1));
    send(cmd(OP_CSRR, CSR_CYCLE, 16'h0));
    drain();
    assert (last_cycle > c1)
      else fail_run($sformatf("FAIL rd_wdata %h, expected above %h", last_cycle, c1));
    send(cmd(OP_CSRW, CSR_INHIBIT, 16'h0001));   // Freeze cycle
    send(cmd(OP_CSRR, CSR_INHIBIT, 16'h0));
    drain();
    send(cmd(OP_CSRR, CSR_CYCLE, 16'h0));
    drain();
    c1 = last_cycle;
    idle(5);
    send(cmd(OP_CSRR, CSR_CYCLE, 16'h0));
    drain();
    assert (last_cycle == c1) else value_error("rd_wdata", last_cycle, c1);
    send(cmd(OP_CSRW, CSR_INHIBIT, 16'h0000));
    drain();
  endtask

  task automatic interrupt_priority();
    int_external     = 1'b1;
    int_extern_cause = 4'd5;
    int_software     = 1'b1;
    idle(3);
    send(cmd(OP_CSRW, CSR_MIE, 16'h0888));
    send(cmd(OP_CSRW, CSR_MSTATUS, 16'h0008));
    send(cmd(OP_NOP, 4'd0, 16'h0));             // External wins
    send(cmd(OP_CSRR, CSR_MSTATUS, 16'h0));
    send(cmd(OP_CSRR, CSR_MIP, 16'h0));
    drain();
    int_external = 1'b0;
    idle(3);
    send(cmd(OP_CSRW, CSR_MSTATUS, 16'h0008));
    send(cmd(OP_NOP, 4'd0, 16'h0));             // Software next
    drain();
    int_software = 1'b0;
    idle(3);
  endtask

  task automatic timer_compare();
    send(cmd(OP_CSRW, CSR_MSTATUS, 16'h0000));
    send(cmd(OP_CSRW, CSR_MIE, 16'h0080));
    send(cmd(OP_MMIOW, 4'd3, 16'h0000));        // mtimecmp high
    send(cmd(OP_MMIOW, 4'd2, 16'h0020));        // mtimecmp low
    send(cmd(OP_MMIOR, 4'd2, 16'h0));
    send(cmd(OP_MMIOR, 4'd3, 16'h0));
    drain();
    wait_mtime(1'b1);
    m_mtip = 1'b1;
    send(cmd(OP_CSRR, CSR_MIP, 16'h0));
    send(cmd(OP_CSRW, CSR_MSTATUS, 16'h0008));
    send(cmd(OP_NOP, 4'd0, 16'h0));             // Timer trap
    send(cmd(OP_MMIOW, 4'd3, 16'hFFFF));        // Push compare far out
    drain();
    wait_mtime(1'b0);
    m_mtip = 1'b0;
    send(cmd(OP_MMIOR, 4'd3, 16'h0));
    send(cmd(OP_CSRW, CSR_MIE, 16'h0000));
    drain();
  endtask

  task automatic nmi_latch();
    int_nmi   = 1'b1;
    nmi_armed = 1'b1;
    idle(3);
    send(cmd(OP_NOP, 4'd0, 16'h0));             // Taken with enables clear
    drain();
    int_nmi = 1'b0;
    idle(3);
    send(cmd(OP_NOP, 4'd0, 16'h0));             // Latch still set
    send(cmd(OP_NOP, 4'd0, 16'h0));
    drain();
  endtask

  task automatic send_random();
    logic [31:0] r;
    logic [31:0] r2;
    logic [3:0]  op, sel;
    r   = lcg_next();
    r2  = lcg_next();
    op  = {1'b0, r[30:28]};                      // 5..7 are illegal
    sel = {1'b0, r[26:24]};
    if (op == 4'd3) sel = 4'd4 + {1'b0, r[26:24]};   // Bad offsets only
    if (op == 4'd4) sel = r[23] ? 4'd4 + {1'b0, r[26:24]} : {3'b001, r[24]};
    // Counter-sensitive commands go into an empty pipeline
    if ((op == 4'd1 && sel == 4'd5) || (op == 4'd2 && sel == 4'd4)) drain();
    send({op, sel, r2[23:16], r2[15:0]});
    if (r[0]) idle(1);
  endtask

  // ----------------------------------------
  // Main sequence
  initial begin
    seed = 32'd69841;
    clk_edges = 0;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_word = '0;
    int_nmi = 1'b0;
    int_external = 1'b0;
    int_extern_cause = 4'd0;
    int_software = 1'b0;
    m_pc = 32'h8000_0000;
    m_instret = '0;
    {m_mie, m_meie, m_mtie, m_msie} = '0;
    {m_icy, m_itm, m_iir} = '0;
    m_mtimecmp = '1;
    m_mtip = 1'b0;
    nmi_armed = 1'b0;
    last_cycle = '0;
    sent = 0;
    repeat (8) @(negedge g_clk);
    reset = 1'b0;
    idle(2);
    cycle_reads();
    interrupt_priority();
    timer_compare();
    nmi_latch();
    while (sent < 2000) send_random();
    drain();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
